//--- source/spl_packet_pkg.sv
// packet format only; parity and error bits in the packet are carried but never checked
package spl_packet_pkg;

  // ----------------------------------------------------------
  // packet geometry
  // ----------------------------------------------------------
  localparam int PKT_BITS      = 72;  // long packet, header plus data plus payload
  localparam int NIBBLE_BITS   = 4;   // one data symbol carries one nibble

  // data symbols per packet, end-of-packet symbol not counted
  localparam int SHORT_NIBBLES = 10;  // 40 bit packet
  localparam int LONG_NIBBLES  = 18;  // 72 bit packet

  // length flag inside the header
  localparam int LONG_BIT      = 1;   // 1 = long, 0 = short

  // wide enough to count up to LONG_NIBBLES
  localparam int CNT_BITS      = $clog2(LONG_NIBBLES + 1);

  // ----------------------------------------------------------
  // types
  // ----------------------------------------------------------
  // short packets use the low 40 bits only
  // upper bits are ignored by the serializer for a short packet
  typedef logic [PKT_BITS-1:0] pkt_t;

endpackage

//--- source/spl_link_pkg.sv
// link coding for the NRZ 2-of-7 protocol; link value and acknowledge both start at zero
package spl_link_pkg;

  // ----------------------------------------------------------
  // symbol and code widths
  // ----------------------------------------------------------
  localparam int SYM_BITS  = 7;  // one wire per bit on the link
  localparam int CODE_BITS = 5;  // end flag plus nibble

  typedef logic [SYM_BITS-1:0] sym_t;

  // wires 5 and 6 change for end of packet
  localparam sym_t SYM_EOP = 7'b1100000;

  // acknowledge crosses into CLK_IN through this many flops
  localparam int ACK_SYNC_STAGES = 2;

  // ----------------------------------------------------------
  // state machines
  // ----------------------------------------------------------
  typedef enum logic [1:0] {
    SER_IDLE,  // waiting for a packet
    SER_PARK,  // packet held while last flit still stalled
    SER_TRAN   // shifting nibbles out
  } ser_state_e;

  typedef enum logic [1:0] {
    OUT_IDLE,  // link quiet
    OUT_TRAN,  // symbol on the wire and unacknowledged
    OUT_WAIT   // next flit already taken on the ack cycle
  } out_state_e;

  // ----------------------------------------------------------
  // NRZ 2-of-7 encoder
  // ----------------------------------------------------------
  // the table gives the two wires to flip for each code
  // the new link value is the old one with those wires inverted
  function automatic sym_t encode_2of7(input logic [CODE_BITS-1:0] code,
                                       input sym_t old_link);
    sym_t flips;
    case (code)
      5'b00000: flips = 7'b0010001;  // 0
      5'b00001: flips = 7'b0010010;  // 1
      5'b00010: flips = 7'b0010100;  // 2
      5'b00011: flips = 7'b0011000;  // 3
      5'b00100: flips = 7'b0100001;  // 4
      5'b00101: flips = 7'b0100010;  // 5
      5'b00110: flips = 7'b0100100;  // 6
      5'b00111: flips = 7'b0101000;  // 7
      5'b01000: flips = 7'b1000001;  // 8
      5'b01001: flips = 7'b1000010;  // 9
      5'b01010: flips = 7'b1000100;  // 10
      5'b01011: flips = 7'b1001000;  // 11
      5'b01100: flips = 7'b0000011;  // 12
      5'b01101: flips = 7'b0000110;  // 13
      5'b01110: flips = 7'b0001100;  // 14
      5'b01111: flips = 7'b0001001;  // 15
      default:  flips = SYM_EOP;     // end flag set, nibble ignored
    endcase
    return old_link ^ flips;
  endfunction

endpackage

//--- source/pkt_serializer.sv
// packet is taken only while pkt_rdy is high; bit LONG_BIT picks 18 or 10 nibbles, LSB first
module pkt_serializer
  import spl_packet_pkg::*;
  import spl_link_pkg::*;
(
  input  logic CLK_IN,
  input  logic RESET_IN,

  // packet side
  input  pkt_t pkt_data,
  input  logic pkt_vld,
  output logic pkt_rdy,

  // flit side, flt_data is the new link value
  output sym_t flt_data,
  output logic flt_vld,
  input  logic flt_rdy
);

  // ----------------------------------------------------------
  // internal signals
  // ----------------------------------------------------------
  pkt_t                pkt_buf;   // remaining nibbles, next one at the bottom
  logic                long_pkt;  // length flag of the packet in flight
  logic [CNT_BITS-1:0] flt_cnt;   // data flits sent so far
  logic                flt_busy;  // flit offered but not taken
  logic                eop;       // all data flits gone, send end symbol
  logic                pkt_take;  // packet accepted this cycle
  ser_state_e          state;

  assign flt_busy = flt_vld && !flt_rdy;
  assign pkt_take = pkt_vld && pkt_rdy;  // rdy only high in idle

  // short packets stop at 10 unless long flag set
  assign eop = (!long_pkt && (flt_cnt == CNT_BITS'(SHORT_NIBBLES))) ||
               (flt_cnt == CNT_BITS'(LONG_NIBBLES));

  // ----------------------------------------------------------
  // packet ready
  // ----------------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      pkt_rdy <= 1'b1;
    end else begin
      case (state)
        SER_IDLE: pkt_rdy <= !pkt_vld;              // drop as soon as one arrives
        SER_PARK: pkt_rdy <= 1'b0;                  // parked packet not started
        default:  pkt_rdy <= eop && !flt_busy;      // end symbol handed over
      endcase
    end
  end

  // ----------------------------------------------------------
  // packet buffer
  // ----------------------------------------------------------
  // first nibble leaves straight from pkt_data when the flit side is free
  always_ff @(posedge CLK_IN) begin
    case (state)
      SER_IDLE: begin
        if (pkt_take && !flt_busy)
          pkt_buf <= pkt_data >> NIBBLE_BITS;  // nibble 0 already encoded
        else if (pkt_take)
          pkt_buf <= pkt_data;                 // park whole packet
      end
      default: begin
        if (!flt_busy)
          pkt_buf <= pkt_buf >> NIBBLE_BITS;   // next nibble down
      end
    endcase
  end

  // length flag, captured with the packet
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN)
      long_pkt <= 1'b0;
    else if (pkt_take)
      long_pkt <= pkt_data[LONG_BIT];
  end

  // ----------------------------------------------------------
  // flit counter
  // ----------------------------------------------------------
  // starts at 1 since the first nibble goes on entry to transmit
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      flt_cnt <= CNT_BITS'(1);
    end else begin
      case (state)
        SER_IDLE,
        SER_PARK: flt_cnt <= CNT_BITS'(1);
        default: begin
          if (!flt_busy)
            flt_cnt <= flt_cnt + CNT_BITS'(1);  // one more flit gone
        end
      endcase
    end
  end

  // ----------------------------------------------------------
  // flit data and valid
  // ----------------------------------------------------------
  // each symbol encoded against the previous flit, which is the link value
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      flt_data <= '0;  // matches idle link
    end else begin
      case (state)
        SER_IDLE: begin
          if (pkt_take && !flt_busy)
            flt_data <= encode_2of7({1'b0, pkt_data[NIBBLE_BITS-1:0]}, flt_data);
        end
        default: begin
          // parked packet sends its first nibble from here too
          if (!flt_busy)
            flt_data <= encode_2of7({eop, pkt_buf[NIBBLE_BITS-1:0]}, flt_data);
        end
      endcase
    end
  end

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      flt_vld <= 1'b0;
    end else begin
      case (state)
        SER_IDLE: flt_vld <= pkt_take || flt_busy;  // new flit or old one stuck
        default:  flt_vld <= 1'b1;                  // always one ready
      endcase
    end
  end

  // ----------------------------------------------------------
  // state machine
  // ----------------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      state <= SER_IDLE;
    end else begin
      case (state)
        SER_IDLE: begin
          if (pkt_take)
            state <= flt_busy ? SER_PARK : SER_TRAN;  // park behind stalled flit
        end
        SER_PARK: begin
          if (!flt_busy)
            state <= SER_TRAN;
        end
        default: begin
          if (eop && !flt_busy)
            state <= SER_IDLE;  // end symbol taken
        end
      endcase
    end
  end

endmodule

//--- source/flit_output_if.sv
// far end must toggle sl_ack once per symbol; a silent far end stalls the link forever
module flit_output_if
  import spl_link_pkg::*;
(
  input  logic CLK_IN,
  input  logic RESET_IN,

  // flit side from the serializer
  input  sym_t flt_data,
  input  logic flt_vld,
  output logic flt_rdy,

  // link side
  output sym_t sl_data_2of7,
  input  logic sl_ack
);

  // ----------------------------------------------------------
  // internal signals
  // ----------------------------------------------------------
  logic [ACK_SYNC_STAGES-1:0] ack_sync;   // sync chain, oldest at top
  logic                       ack_s;      // synchronized acknowledge
  logic                       old_ack;    // previous synced level
  logic                       acked;      // ack level changed
  logic                       send_flit;  // load link register
  out_state_e                 state;

  // ----------------------------------------------------------
  // acknowledge synchronizer and edge detect
  // ----------------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN)
      ack_sync <= '0;
    else
      ack_sync <= {ack_sync[ACK_SYNC_STAGES-2:0], sl_ack};  // shift in raw ack
  end

  assign ack_s = ack_sync[ACK_SYNC_STAGES-1];

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN)
      old_ack <= 1'b0;
    else
      old_ack <= ack_s;
  end

  // two-phase protocol so either edge counts
  assign acked = (old_ack != ack_s);

  // ----------------------------------------------------------
  // link register
  // ----------------------------------------------------------
  always_comb begin
    case (state)
      OUT_IDLE: send_flit = flt_vld;            // link free
      OUT_TRAN: send_flit = acked && flt_vld;   // ack frees the wire
      default:  send_flit = 1'b0;               // wait for ack of taken flit
    endcase
  end

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN)
      sl_data_2of7 <= '0;
    else if (send_flit)
      sl_data_2of7 <= flt_data;  // already NRZ, two wires change
  end

  // ----------------------------------------------------------
  // flit ready
  // ----------------------------------------------------------
  // in transmit a flit may be loaded while rdy is still low
  // rdy then rises on the next cycle to complete that transfer
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      flt_rdy <= 1'b1;
    end else begin
      case (state)
        OUT_IDLE: begin
          if (flt_vld)
            flt_rdy <= 1'b0;  // one symbol out, hold the next
        end
        default:  flt_rdy <= acked;
      endcase
    end
  end

  // ----------------------------------------------------------
  // state machine
  // ----------------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      state <= OUT_IDLE;
    end else begin
      case (state)
        OUT_IDLE: begin
          if (flt_vld)
            state <= OUT_TRAN;
        end
        OUT_TRAN: begin
          if (acked)
            state <= flt_vld ? OUT_WAIT : OUT_IDLE;  // next flit used early
        end
        default:  state <= acked ? OUT_IDLE : OUT_TRAN;
      endcase
    end
  end

endmodule

//--- source/spinnaker_link_sender.sv
// transmit half only; one symbol in flight on the wire and one held in the serializer
module spinnaker_link_sender
  import spl_packet_pkg::*;
  import spl_link_pkg::*;
(
  input  logic CLK_IN,
  input  logic RESET_IN,

  // synchronous packet port
  input  pkt_t pkt_data,
  input  logic pkt_vld,
  output logic pkt_rdy,

  // asynchronous 2-of-7 link
  output sym_t sl_data_2of7,
  input  logic sl_ack
);

  // ----------------------------------------------------------
  // flit channel between the two halves
  // ----------------------------------------------------------
  sym_t flt_data;  // next link value
  logic flt_vld;
  logic flt_rdy;

  // packet to encoded symbols
  pkt_serializer u_ser (
    .CLK_IN   (CLK_IN),
    .RESET_IN (RESET_IN),
    .pkt_data (pkt_data),
    .pkt_vld  (pkt_vld),
    .pkt_rdy  (pkt_rdy),
    .flt_data (flt_data),
    .flt_vld  (flt_vld),
    .flt_rdy  (flt_rdy)
  );

  // symbols onto the wire, paced by the far end ack
  flit_output_if u_out (
    .CLK_IN       (CLK_IN),
    .RESET_IN     (RESET_IN),
    .flt_data     (flt_data),
    .flt_vld      (flt_vld),
    .flt_rdy      (flt_rdy),
    .sl_data_2of7 (sl_data_2of7),
    .sl_ack       (sl_ack)
  );

endmodule

//--- test/link_rx_model.sv
// behavioral far end; assumes link and ack both start at zero, one symbol outstanding at a time
module link_rx_model
  import spl_link_pkg::*;
#(
  parameter logic [31:0] SEED      = 32'd8,
  parameter int          MAX_DELAY = 8   // ack delay range 0..MAX_DELAY cycles
) (
  input  logic       CLK_IN,
  input  logic       RESET_IN,
  input  sym_t       sl_data_2of7,
  output logic       sl_ack,
  output logic       nib_vld,   // one cycle pulse per data symbol
  output logic [3:0] nib,
  output logic       eop_vld,   // one cycle pulse per end symbol
  output logic       sym_bad    // wire change is not a table code
);

  sym_t        prev_link;
  logic [31:0] rng;
  logic [5:0]  code;      // {valid, eop, nibble}
  int          delay;
  int          wait_cnt;
  logic        waiting;   // ack toggle pending

  initial begin
    sl_ack    = 1'b0;
    prev_link = '0;
    rng       = SEED;
    waiting   = 1'b0;
    wait_cnt  = 0;
    nib_vld   = 1'b0;
    nib       = '0;
    eop_vld   = 1'b0;
    sym_bad   = 1'b0;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // inverse 2-of-7 table, flipped wires to code
  function automatic logic [5:0] decode_flips(input sym_t flips);
    case (flips)
      7'h11: return 6'h20;
      7'h12: return 6'h21;
      7'h14: return 6'h22;
      7'h18: return 6'h23;
      7'h21: return 6'h24;
      7'h22: return 6'h25;
      7'h24: return 6'h26;
      7'h28: return 6'h27;
      7'h41: return 6'h28;
      7'h42: return 6'h29;
      7'h44: return 6'h2a;
      7'h48: return 6'h2b;
      7'h03: return 6'h2c;
      7'h06: return 6'h2d;
      7'h0c: return 6'h2e;
      7'h09: return 6'h2f;
      7'h60: return 6'h30;  // end of packet
      default: return 6'h00;
    endcase
  endfunction

  always @(posedge CLK_IN) begin
    if (RESET_IN) begin
      sl_ack    <= 1'b0;
      prev_link <= '0;
      waiting   <= 1'b0;
      nib_vld   <= 1'b0;
      eop_vld   <= 1'b0;
      sym_bad   <= 1'b0;
    end else begin
      nib_vld <= 1'b0;
      eop_vld <= 1'b0;
      sym_bad <= 1'b0;
      if (sl_data_2of7 != prev_link) begin
        code = decode_flips(sl_data_2of7 ^ prev_link);  // NRZ, so xor gives the flips
        prev_link <= sl_data_2of7;
        sym_bad   <= !code[5];
        eop_vld   <= code[5] && code[4];
        nib_vld   <= code[5] && !code[4];
        nib       <= code[3:0];
        rng   = xorshift32(rng);
        delay = int'(rng % 32'(MAX_DELAY + 1));
        if (delay == 0) begin
          sl_ack <= !sl_ack;  // same cycle ack
        end else begin
          waiting  <= 1'b1;
          wait_cnt <= delay;
        end
      end else if (waiting) begin
        if (wait_cnt == 1) begin
          sl_ack  <= !sl_ack;  // two-phase, one transition per symbol
          waiting <= 1'b0;
        end else begin
          wait_cnt <= wait_cnt - 1;
        end
      end
    end
  end

endmodule

//--- test/tb_spinnaker_link_sender.sv
// 40 random packets against the far end model; the run stops at the first failed check
module tb_spinnaker_link_sender
  import spl_packet_pkg::*;
  import spl_link_pkg::*;
();

  localparam int NUM_PKTS   = 40;
  localparam int MAX_CYCLES = 20000;  // 40 x 19 symbols x 16 cycles plus margin
  localparam int DRAIN      = 30;     // idle cycles to catch stray symbols

  logic        CLK_IN = 1'b0;
  logic        RESET_IN;
  pkt_t        pkt_data;
  logic        pkt_vld;
  logic        pkt_rdy;
  sym_t        sl_data_2of7;
  logic        sl_ack;
  logic        nib_vld;
  logic [3:0]  nib;
  logic        eop_vld;
  logic        sym_bad;

  logic [31:0] rng_state    = 32'd8;
  pkt_t        exp_q[$];           // accepted with end symbol not yet seen
  int          eop_cnt      = 0;
  int          nib_idx      = 0;   // nibbles seen of the front packet
  int          cycle_cnt    = 0;
  sym_t        last_link    = '0;
  logic        last_ack     = 1'b0;
  int          link_changes = 0;   // symbols since last ack toggle

  always #10 CLK_IN = ~CLK_IN;

  spinnaker_link_sender u_dut (
    .CLK_IN (CLK_IN), .RESET_IN (RESET_IN),
    .pkt_data (pkt_data), .pkt_vld (pkt_vld), .pkt_rdy (pkt_rdy),
    .sl_data_2of7 (sl_data_2of7), .sl_ack (sl_ack)
  );

  link_rx_model u_rx (
    .CLK_IN (CLK_IN), .RESET_IN (RESET_IN),
    .sl_data_2of7 (sl_data_2of7), .sl_ack (sl_ack),
    .nib_vld (nib_vld), .nib (nib), .eop_vld (eop_vld), .sym_bad (sym_bad)
  );

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int nibble_count(input pkt_t pkt);
    return pkt[LONG_BIT] ? LONG_NIBBLES : SHORT_NIBBLES;
  endfunction

  function automatic string packet_test(input pkt_t pkt);
    if (pkt[LONG_BIT])
      return "long_packet";
    return "short_packet";
  endfunction

  // least significant nibble goes first
  function automatic logic [3:0] expected_nibble(input pkt_t pkt, input int idx);
    pkt_t shifted;
    shifted = pkt >> (NIBBLE_BITS * idx);
    return shifted[3:0];
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_mismatch(input string test, input int expected, input int actual);
    abort_run($sformatf("FAILED %s: expected 0x%0h, actual 0x%0h", test, expected, actual));
  endtask

  task automatic send_packet(input pkt_t pkt, input int gap);
    repeat (gap) begin
      pkt_vld <= 1'b0;
      @(posedge CLK_IN);
    end
    pkt_vld  <= 1'b1;
    pkt_data <= pkt;
    @(posedge CLK_IN);
    while (!pkt_rdy) @(posedge CLK_IN);  // taken on this edge
  endtask

  // ------------------------------------------------------------
  // monitors
  // ------------------------------------------------------------
  always @(posedge CLK_IN) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES)
      abort_run($sformatf("timeout: run not finished after %0d cycles", MAX_CYCLES));
  end

  // two wires per symbol and one symbol per ack
  always @(posedge CLK_IN) begin
    if (!RESET_IN) begin
      if (sl_ack != last_ack)
        link_changes = 0;
      if (sl_data_2of7 != last_link) begin
        assert ($countones(sl_data_2of7 ^ last_link) == 2)
          else report_mismatch("link_code wires", 2, $countones(sl_data_2of7 ^ last_link));
        link_changes++;
        assert (link_changes <= 1)
          else report_mismatch("back_pressure symbols per ack", 1, link_changes);
      end
      last_link = sl_data_2of7;
      last_ack  = sl_ack;
    end
  end

  // scoreboard of accepted packets against decoded nibbles
  always @(posedge CLK_IN) begin
    if (!RESET_IN) begin
      if (pkt_vld && pkt_rdy)
        exp_q.push_back(pkt_data);
      assert (!sym_bad) else abort_run("link_code: wire change is not a 2-of-7 code");
      if (nib_vld) begin
        assert (exp_q.size() > 0) else abort_run("data symbol with no packet outstanding");
        assert (nib_idx < nibble_count(exp_q[0]))
          else report_mismatch({packet_test(exp_q[0]), " nibble count"},
                               nibble_count(exp_q[0]), nib_idx + 1);
        assert (nib == expected_nibble(exp_q[0], nib_idx))
          else report_mismatch($sformatf("%s nibble %0d", packet_test(exp_q[0]), nib_idx),
                               int'(expected_nibble(exp_q[0], nib_idx)), int'(nib));
        nib_idx++;
      end
      if (eop_vld) begin
        assert (exp_q.size() > 0) else abort_run("end symbol with no packet outstanding");
        assert (nib_idx == nibble_count(exp_q[0]))
          else report_mismatch({packet_test(exp_q[0]), " nibble count"},
                               nibble_count(exp_q[0]), nib_idx);
        void'(exp_q.pop_front());
        nib_idx = 0;
        eop_cnt <= eop_cnt + 1;
      end
    end
  end

  // ------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------
  initial begin
    pkt_t pkt;
    int   gap;
    RESET_IN = 1'b1;
    pkt_vld  = 1'b0;
    pkt_data = '0;
    repeat (3) @(posedge CLK_IN);
    RESET_IN <= 1'b0;
    @(posedge CLK_IN);
    assert (pkt_rdy == 1'b1) else report_mismatch("reset_state pkt_rdy", 1, int'(pkt_rdy));
    assert (sl_data_2of7 == '0)
      else report_mismatch("reset_state link", 0, int'(sl_data_2of7));

    for (int i = 0; i < NUM_PKTS; i++) begin
      rng_state  = xorshift32(rng_state);
      pkt[31:0]  = rng_state;
      rng_state  = xorshift32(rng_state);
      pkt[63:32] = rng_state;
      rng_state  = xorshift32(rng_state);
      pkt[71:64] = rng_state[7:0];
      pkt[LONG_BIT] = rng_state[8];                       // random length
      gap = rng_state[9] ? 0 : int'(rng_state[11:10]);    // often back to back
      send_packet(pkt, gap);
    end
    pkt_vld <= 1'b0;

    // every end symbol pops one accepted packet, so this count closes the scoreboard
    while (eop_cnt < NUM_PKTS) @(posedge CLK_IN);
    repeat (DRAIN) @(posedge CLK_IN);
    if (pkt_rdy) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      report_mismatch("end_state pkt_rdy", 1, int'(pkt_rdy));
    end
  end

endmodule

//--- sim.f
source/spl_packet_pkg.sv
source/spl_link_pkg.sv
source/pkt_serializer.sv
source/flit_output_if.sv
source/spinnaker_link_sender.sv
test/link_rx_model.sv
test/tb_spinnaker_link_sender.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the link sender testbench with Verilator.
# The exit status is the simulator's: nonzero on any $fatal.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_spinnaker_link_sender \
  -Mdir obj_dir -f sim.f
build_status=$?
if [ "$build_status" -ne 0 ]; then
  echo "verilator build returned status $build_status"
  exit "$build_status"
fi

./obj_dir/Vtb_spinnaker_link_sender
sim_status=$?
if [ "$sim_status" -ne 0 ]; then
  echo "simulation returned status $sim_status"
  exit "$sim_status"
fi
exit 0
